// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = alu_tb
FILELIST = alu_top.f

OBJDIR  = obj_dir
SIM     = $(OBJDIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a listed source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== alu_top.f ====
+incdir+include
source/alu_pkg.sv
source/alu_adder.sv
source/alu_logic.sv
source/alu_shifter.sv
source/alu_ctrl.sv
source/alu_writeback.sv
source/alu_top.sv
testbench/alu_assertions.sv
testbench/alu_tb.sv

// ==== include/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// datapath width of the alu stage
`define ALU_WIDTH 32

// status flags carried in eflags, set_eflags and the merged flag word
`define ALU_NFLAGS 6

// flag bit positions, same order as the x86 subset used by the core
`define FLAG_OF 5
`define FLAG_SF 4
`define FLAG_ZF 3
`define FLAG_AF 2
`define FLAG_CF 1
`define FLAG_PF 0

// shift count taken from b[4:0]
`define ALU_SHCNT_W 5

`endif

// ==== source/alu_adder.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// size aware add, carry in fixed at 0
module alu_adder
   import alu_pkg::*;
(
   input  logic [`ALU_WIDTH-1:0] a,
   input  logic [`ALU_WIDTH-1:0] b,
   input  opsize_e               size,
   output unit_out_t             res
);

   logic [`ALU_WIDTH:0] sum; // one extra bit for the 32 bit carry
   logic                c8, c16;

   assign sum = {1'b0, a} + {1'b0, b};

   // carry into bit n is a^b^sum at n, i.e. carry out of bit n-1
   assign c8  = a[8] ^ b[8] ^ sum[8];
   assign c16 = a[16] ^ b[16] ^ sum[16];

   assign res.af = a[4] ^ b[4] ^ sum[4]; // nibble carry out of bit 3

   always_comb begin
      case (size)
         SIZE_8: begin
            res.value = {24'h0, sum[7:0]};
            res.cf    = c8;
            res.of    = (a[7] == b[7]) && (sum[7] != a[7]); // same signs in, other sign out
         end
         SIZE_16: begin
            res.value = {16'h0, sum[15:0]};
            res.cf    = c16;
            res.of    = (a[15] == b[15]) && (sum[15] != a[15]);
         end
         default: begin
            res.value = sum[`ALU_WIDTH-1:0];
            res.cf    = sum[`ALU_WIDTH];
            res.of    = (a[31] == b[31]) && (sum[31] != a[31]);
         end
      endcase
   end

endmodule

// ==== source/alu_ctrl.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// op and size decode, result select and flag write mask
module alu_ctrl
   import alu_pkg::*;
(
   input  alu_req_t  req,
   input  unit_out_t add_res,
   input  unit_out_t logic_res,
   input  unit_out_t shift_res,
   output opsize_e   size_eff,  // normalised size for units and flag logic
   output unit_out_t sel_res,   // chosen unit result
   output flags_t    set_mask   // which flags get written
);

   logic [`ALU_SHCNT_W-1:0] shcnt;
   logic                    is_shift;

   assign shcnt    = req.b[`ALU_SHCNT_W-1:0]; // upper count bits ignored
   assign is_shift = (req.op == ALU_SAL) || (req.op == ALU_SAR);

   // shifts always run at 32 bit, unknown size codes too
   always_comb begin
      size_eff = SIZE_32;
      if (!is_shift) begin
         case (req.size)
            SIZE_8:  size_eff = SIZE_8;
            SIZE_16: size_eff = SIZE_16;
            default: size_eff = SIZE_32;
         endcase
      end
   end

   // result source per op
   always_comb begin
      sel_res = '0; // unused codes give value 0
      case (req.op)
         ALU_CMOVC: begin
            sel_res.value = req.eflags[`FLAG_CF] ? req.b : req.a; // move if carry set
         end
         ALU_MOV:                  sel_res.value = req.b;
         ALU_ADD:                  sel_res = add_res;
         ALU_AND, ALU_OR, ALU_NOT: sel_res = logic_res;
         ALU_SAL, ALU_SAR:         sel_res = shift_res; // count 0 passes a through
         default:                  sel_res = '0;
      endcase
   end

   // write mask, cmovc / mov / not leave flags alone
   always_comb begin
      set_mask = '0;
      case (req.op)
         ALU_ADD: set_mask = '1; // all six flags
         ALU_AND, ALU_OR: begin
            set_mask = '1;
            set_mask[`FLAG_AF] = 1'b0; // af undefined for logic ops, keep old value
         end
         ALU_SAL, ALU_SAR: begin
            if (shcnt != '0) begin
               set_mask[`FLAG_SF] = 1'b1;
               set_mask[`FLAG_ZF] = 1'b1;
               set_mask[`FLAG_CF] = 1'b1;
               set_mask[`FLAG_PF] = 1'b1;
               set_mask[`FLAG_OF] = (shcnt == `ALU_SHCNT_W'd1); // of only on single shift
            end
         end
         default: set_mask = '0;
      endcase
   end

endmodule

// ==== source/alu_logic.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// and / or / not, result zero extended above the operand size
module alu_logic
   import alu_pkg::*;
(
   input  logic [`ALU_WIDTH-1:0] a,
   input  logic [`ALU_WIDTH-1:0] b,
   input  alu_op_e               op,
   input  opsize_e               size,
   output unit_out_t             res
);

   logic [`ALU_WIDTH-1:0] raw;
   logic [`ALU_WIDTH-1:0] size_mask;

   always_comb begin
      case (op)
         ALU_AND: raw = a & b;
         ALU_OR:  raw = a | b;
         ALU_NOT: raw = ~a; // unary, b not used
         default: raw = '0;
      endcase
   end

   always_comb begin
      case (size)
         SIZE_8:  size_mask = 32'h0000_00ff;
         SIZE_16: size_mask = 32'h0000_ffff;
         default: size_mask = 32'hffff_ffff;
      endcase
   end

   assign res.value = raw & size_mask;
   assign res.cf    = 1'b0; // logic ops clear cf and of
   assign res.of    = 1'b0;
   assign res.af    = 1'b0; // not in mask anyway

endmodule

// ==== source/alu_pkg.sv ====
`include "alu_params.svh"

package alu_pkg;

   // alu op codes, numbering kept from the core decoder
   typedef enum logic [3:0] {
      ALU_CMOVC = 4'd0,  // move on carry
      ALU_ADD   = 4'd1,
      ALU_AND   = 4'd2,
      ALU_MOV   = 4'd4,
      ALU_NOT   = 4'd7,
      ALU_OR    = 4'd8,
      ALU_SAL   = 4'd12, // shift arithmetic left
      ALU_SAR   = 4'd13  // shift arithmetic right
   } alu_op_e;

   // operand size, other codes treated as 32 bit
   typedef enum logic [2:0] {
      SIZE_8  = 3'd1,
      SIZE_16 = 3'd2,
      SIZE_32 = 3'd3
   } opsize_e;

   typedef logic [`ALU_NFLAGS-1:0] flags_t; // {of, sf, zf, af, cf, pf}

   // one request per cycle into the stage
   typedef struct packed {
      alu_op_e               op;
      opsize_e               size;
      logic [`ALU_WIDTH-1:0] a;      // destination operand
      logic [`ALU_WIDTH-1:0] b;      // source operand, shift count in b[4:0]
      flags_t                eflags; // incoming flags
   } alu_req_t;

   // registered stage output
   typedef struct packed {
      logic [`ALU_WIDTH-1:0] value;
      flags_t                eflags;     // merged flag word
      flags_t                set_eflags; // flag write mask
   } alu_result_t;

   // common return of adder, logic unit and shifter
   typedef struct packed {
      logic [`ALU_WIDTH-1:0] value;
      logic                  cf;
      logic                  of;
      logic                  af;
   } unit_out_t;

endpackage

// ==== source/alu_shifter.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// 32 bit sal / sar with last-out carry
module alu_shifter
   import alu_pkg::*;
(
   input  logic [`ALU_WIDTH-1:0]   a,
   input  logic [`ALU_SHCNT_W-1:0] count,
   input  logic                    arith_right, // 1 for sar, 0 for sal
   output unit_out_t               res
);

   logic [`ALU_WIDTH:0]   left_ext;  // carry bit above the msb
   logic [`ALU_WIDTH:0]   right_ext; // carry bit below the lsb
   logic [`ALU_WIDTH-1:0] shifted;
   logic                  last_out;

   // shifted out bit lands in the extra position, stays 0 for count 0
   assign left_ext  = {1'b0, a} << count;
   assign right_ext = $unsigned($signed({a, 1'b0}) >>> count); // sign fill from a[31]

   always_comb begin
      if (arith_right) begin
         shifted  = right_ext[`ALU_WIDTH:1];
         last_out = right_ext[0]; // a[count-1]
      end else begin
         shifted  = left_ext[`ALU_WIDTH-1:0];
         last_out = left_ext[`ALU_WIDTH]; // a[32-count]
      end
   end

   assign res.value = shifted;
   assign res.cf    = last_out;
   assign res.af    = 1'b0;

   // of defined only for a one bit shift
   always_comb begin
      res.of = 1'b0;
      if (count == `ALU_SHCNT_W'd1 && !arith_right) begin
         res.of = shifted[`ALU_WIDTH-1] ^ last_out; // sign changed by the shift
      end
   end

endmodule

// ==== source/alu_top.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// registered alu stage, one cycle latency, new request every cycle
module alu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  alu_pkg::alu_req_t    alu_in,
   output alu_pkg::alu_result_t alu_result
);

   alu_pkg::unit_out_t add_res;
   alu_pkg::unit_out_t logic_res;
   alu_pkg::unit_out_t shift_res;
   alu_pkg::unit_out_t sel_res;
   alu_pkg::opsize_e   size_eff;
   alu_pkg::flags_t    set_mask;

   alu_ctrl u_ctrl (
      .req       (alu_in),
      .add_res   (add_res),
      .logic_res (logic_res),
      .shift_res (shift_res),
      .size_eff  (size_eff),
      .sel_res   (sel_res),
      .set_mask  (set_mask)
   );

   alu_adder u_adder (.a(alu_in.a), .b(alu_in.b), .size(size_eff), .res(add_res));

   alu_logic u_logic (.a(alu_in.a), .b(alu_in.b), .op(alu_in.op), .size(size_eff), .res(logic_res));

   // op bit 0 tells sar (13) from sal (12)
   alu_shifter u_shifter (
      .a           (alu_in.a),
      .count       (alu_in.b[`ALU_SHCNT_W-1:0]),
      .arith_right (alu_in.op[0]),
      .res         (shift_res)
   );

   alu_writeback u_writeback (
      .clk       (clk),
      .rst_n     (rst_n),
      .res       (sel_res),
      .size      (size_eff),
      .set_mask  (set_mask),
      .eflags_in (alu_in.eflags),
      .result    (alu_result)
   );

endmodule

// ==== source/alu_writeback.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// sf / zf / pf, flag merge and the single pipeline register
module alu_writeback
   import alu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  unit_out_t   res,
   input  opsize_e     size,
   input  flags_t      set_mask,
   input  flags_t      eflags_in,
   output alu_result_t result
);

   flags_t new_flags;
   flags_t merged;
   logic   sf, zf;

   // sign and zero at the operand size
   always_comb begin
      case (size)
         SIZE_8: begin
            sf = res.value[7];
            zf = (res.value[7:0] == 8'h0);
         end
         SIZE_16: begin
            sf = res.value[15];
            zf = (res.value[15:0] == 16'h0);
         end
         default: begin
            sf = res.value[`ALU_WIDTH-1];
            zf = (res.value == '0);
         end
      endcase
   end

   always_comb begin
      new_flags              = '0;
      new_flags[`FLAG_OF]    = res.of;
      new_flags[`FLAG_SF]    = sf;
      new_flags[`FLAG_ZF]    = zf;
      new_flags[`FLAG_AF]    = res.af;
      new_flags[`FLAG_CF]    = res.cf;
      new_flags[`FLAG_PF]    = ~^res.value[7:0]; // even parity of the low byte
   end

   assign merged = (new_flags & set_mask) | (eflags_in & ~set_mask); // unmasked bits keep old flags

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result <= '0; // no flag write signalled out of reset
      end else begin
         result.value      <= res.value;
         result.eflags     <= merged;
         result.set_eflags <= set_mask;
      end
   end

endmodule

// ==== testbench/alu_assertions.sv ====
`timescale 1ns/1ps
`include "alu_params.svh"

// checks on the registered alu stage bound into alu_top
module alu_assertions
   import alu_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input alu_req_t    alu_in,
   input alu_result_t alu_result
);

   logic sized_op;       // ops that zero extend above the operand size
   logic no_af_op;       // logic and shift ops never write af
   int   fail_count = 0; // failed assertions so far

   assign sized_op = alu_in.op inside {ALU_ADD, ALU_AND, ALU_OR, ALU_NOT};
   assign no_af_op = alu_in.op inside {ALU_AND, ALU_OR, ALU_NOT, ALU_SAL, ALU_SAR};

   // result seen at edge n+1 belongs to the request sampled at edge n
   a_keep_flags: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         ((alu_result.eflags ^ $past(alu_in.eflags)) & ~alu_result.set_eflags) == '0)
      else begin
         fail_count = fail_count + 1;
         $error("flags outside the write mask differ from the incoming flags");
      end

   a_zero_ext8: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) && $past(sized_op) && $past(alu_in.size) == SIZE_8 |->
         alu_result.value[31:8] == '0)
      else begin
         fail_count = fail_count + 1;
         $error("8 bit result has upper bits set");
      end

   a_no_af: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) && $past(no_af_op) |-> !alu_result.set_eflags[`FLAG_AF])
      else begin
         fail_count = fail_count + 1;
         $error("af in the write mask for a logic or shift op");
      end

endmodule

bind alu_top alu_assertions u_assertions (
   .clk(clk), .rst_n(rst_n), .alu_in(alu_in), .alu_result(alu_result)
);

// ==== testbench/alu_tb.sv ====
`timescale 1ns/1ps

// table driven testbench with one request per cycle and each result checked one edge later
module alu_tb
   import alu_pkg::*;
();

   localparam int RESET_CYCLES = 5;
   localparam int SLACK_CYCLES = 20;

   typedef struct packed {
      alu_op_e     op;
      opsize_e     size;
      logic [31:0] a;
      logic [31:0] b;
      flags_t      fin;   // incoming eflags
      logic [31:0] val;   // expected value
      flags_t      flags; // expected merged flags {of sf zf af cf pf}
      flags_t      mask;  // expected set_eflags
   } row_t;

   logic        clk;
   logic        rst_n;
   alu_req_t    alu_in;
   alu_result_t alu_result;
   row_t        rows[$];
   int          cycles = 0;

   alu_top u_dut (.clk(clk), .rst_n(rst_n), .alu_in(alu_in), .alu_result(alu_result));

   initial clk = 1'b0;
   always #4 clk = ~clk; // 8 ns period

   // run limit grows with the table
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (u_dut.u_assertions.fail_count != 0) begin
         $display("a bound assertion failed before %0t", $time);
         $display("TEST FAIL");
         $fatal(1, "assertion failure");
      end else if (cycles > RESET_CYCLES + rows.size() + SLACK_CYCLES) begin
         $display("run did not finish within %0d clock cycles", cycles);
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
         $display("TEST FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic push_row(input alu_op_e op, input opsize_e size, input logic [31:0] a, b,
                           input flags_t fin, input logic [31:0] val, input flags_t flags, mask);
      rows.push_back(row_t'{op, size, a, b, fin, val, flags, mask});
   endtask

   // op, size, a, b, flags in, value, flags out, mask
   task automatic fill_table();
      push_row(ALU_ADD, SIZE_8, 'h123456ff, 'h00000001, 6'b010000, 'h00000000, 6'b001111, 6'b111111);
      push_row(ALU_ADD, SIZE_8, 'h0000007f, 'h00000001, 6'b000000, 'h00000080, 6'b110100, 6'b111111);
      push_row(ALU_ADD, SIZE_16, 'h00007fff, 'h00000001, 6'b000000, 'h00008000, 6'b110101, 6'b111111);
      push_row(ALU_ADD, SIZE_16, 'habcdffff, 'h00000001, 6'b000000, 'h00000000, 6'b001111, 6'b111111);
      push_row(ALU_ADD, SIZE_32, 'h7fffffff, 'h00000001, 6'b000000, 'h80000000, 6'b110101, 6'b111111);
      push_row(ALU_ADD, SIZE_32, 'h80000000, 'h80000000, 6'b000000, 'h00000000, 6'b101011, 6'b111111);
      push_row(ALU_ADD, SIZE_32, 'h00001230, 'h00000104, 6'b111111, 'h00001334, 6'b000000, 6'b111111);
      // logic ops clear of and cf and keep the incoming af
      push_row(ALU_AND, SIZE_8, 'hffffff0f, 'h123456f3, 6'b100110, 'h00000003, 6'b000101, 6'b111011);
      push_row(ALU_AND, SIZE_16, 'h0000f0f0, 'hffff0f0f, 6'b000000, 'h00000000, 6'b001001, 6'b111011);
      push_row(ALU_AND, SIZE_32, 'h800000ff, 'hffffff0f, 6'b000100, 'h8000000f, 6'b010101, 6'b111011);
      push_row(ALU_OR, SIZE_8, 'h00000080, 'hffffff01, 6'b100010, 'h00000081, 6'b010001, 6'b111011);
      push_row(ALU_OR, SIZE_16, 'h12340100, 'h00000010, 6'b000000, 'h00000110, 6'b000000, 6'b111011);
      push_row(ALU_OR, SIZE_32, 'h0f000000, 'h70000003, 6'b000100, 'h7f000003, 6'b000101, 6'b111011);
      push_row(ALU_NOT, SIZE_8, 'h12345600, 'h00000000, 6'b101010, 'h000000ff, 6'b101010, 6'b000000);
      push_row(ALU_NOT, SIZE_16, 'hffff00ff, 'h00000000, 6'b010101, 'h0000ff00, 6'b010101, 6'b000000);
      push_row(ALU_NOT, SIZE_32, 'h0f0f0f0f, 'h00000000, 6'b000000, 'hf0f0f0f0, 6'b000000, 6'b000000);
      push_row(ALU_NOT, opsize_e'(3'd0), 'h0, 'h0, 6'b000000, 'hffffffff, 6'b000000, 6'b000000);
      push_row(ALU_MOV, SIZE_8, 'h11111111, 'hdeadbeef, 6'b111111, 'hdeadbeef, 6'b111111, 6'b000000);
      push_row(ALU_CMOVC, SIZE_32, 'haaaaaaaa, 'h55555555, 6'b000010, 'h55555555, 6'b000010, 6'b000000);
      push_row(ALU_CMOVC, SIZE_32, 'haaaaaaaa, 'h55555555, 6'b111101, 'haaaaaaaa, 6'b111101, 6'b000000);
      push_row(alu_op_e'(4'd3), SIZE_32, 'h12345678, 'h1, 6'b101101, 'h0, 6'b101101, 6'b000000);
      // shifts run at 32 bit and take the count from b[4:0] only
      push_row(ALU_SAL, SIZE_8, 'h12345678, 'hffffffe0, 6'b111000, 'h12345678, 6'b111000, 6'b000000);
      push_row(ALU_SAL, SIZE_32, 'h40000001, 'h00000001, 6'b000100, 'h80000002, 6'b110100, 6'b111011);
      push_row(ALU_SAL, SIZE_32, 'hc0000000, 'h00000001, 6'b000000, 'h80000000, 6'b010011, 6'b111011);
      push_row(ALU_SAL, SIZE_32, 'h03000001, 'h00000007, 6'b100000, 'h80000080, 6'b110010, 6'b011011);
      push_row(ALU_SAR, SIZE_32, 'h87654321, 'h000000a0, 6'b010101, 'h87654321, 6'b010101, 6'b000000);
      push_row(ALU_SAR, SIZE_32, 'h80000003, 'h00000001, 6'b100000, 'hc0000001, 6'b010010, 6'b111011);
      push_row(ALU_SAR, SIZE_32, 'hf0000040, 'h00000007, 6'b000000, 'hffe00000, 6'b010011, 6'b011011);
      push_row(ALU_SAR, SIZE_32, 'h00000106, 'h00000102, 6'b000000, 'h00000041, 6'b000011, 6'b011011);
   endtask

   initial begin
      void'($urandom(32'h6b08cfdb));
      alu_in = '0;
      rst_n  = 1'b0;
      fill_table();
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         #1;
         alu_in.op     = ALU_ADD; // junk add writes value, flags and mask unless held in reset
         alu_in.a      = $urandom();
         alu_in.b      = $urandom();
         alu_in.eflags = flags_t'($urandom());
      end
      rst_n = 1'b1;
      check("value after reset", alu_result.value, 32'h0);
      check("flags after reset", {20'h0, alu_result.eflags, alu_result.set_eflags}, 32'h0);
      // next request goes in while the previous one is checked so no cycle is idle
      foreach (rows[i]) begin
         alu_in.op     = rows[i].op;
         alu_in.size   = rows[i].size;
         alu_in.a      = rows[i].a;
         alu_in.b      = rows[i].b;
         alu_in.eflags = rows[i].fin;
         @(posedge clk);
         #1; // sample after the register settles
         check($sformatf("row %0d value", i), alu_result.value, rows[i].val);
         check($sformatf("row %0d flags", i), {26'h0, alu_result.eflags}, {26'h0, rows[i].flags});
         check($sformatf("row %0d mask", i), {26'h0, alu_result.set_eflags}, {26'h0, rows[i].mask});
      end
      @(posedge clk); // bound assertions look at the last result on this edge
      #1;
      if (u_dut.u_assertions.fail_count != 0) begin
         $display("%0d bound assertion failures", u_dut.u_assertions.fail_count);
         $display("TEST FAIL");
         $fatal(1, "assertion failure");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule
